// ==== dv/core_golden.txt ====
# P addr word | D addr doubleword | E rd value (in retire order) | S addr value
# All fields hex; rd 0 marks a retire without a register write
P 00000000 00500093
P 00000004 ffd00113
P 00000008 002081b3
P 0000000c 40208233
P 00000010 0020f2b3
P 00000014 0020e333
P 00000018 0020c3b3
P 0000001c 10000413
P 00000020 00043483
P 00000024 00148533
P 00000028 00a43423
P 0000002c 00843583
P 00000030 00a58463
P 00000034 00100613
P 00000038 00208463
P 0000003c 008006ef
P 00000040 00700713
P 00000044 00970793
P 00000048 0000006f
D 00000100 123456789abcdef0
D 00000108 deadbeef00000108
E 01 0000000000000005
E 02 fffffffffffffffd
E 03 0000000000000002
E 04 0000000000000008
E 05 0000000000000005
E 06 fffffffffffffffd
E 07 fffffffffffffff8
E 08 0000000000000100
E 09 123456789abcdef0
E 0a 123456789abcdef5
E 00 0000000000000000
E 0b 123456789abcdef5
E 00 0000000000000000
E 00 0000000000000000
E 0d 0000000000000040
E 0f 0000000000000009
S 00000108 123456789abcdef5

// ==== dv/core_tb.sv ====
`include "core_settings.svh"

module core_tb;
  timeunit 1ns;
  timeprecision 100ps;

  logic                    clk;
  logic                    reset;
  logic [`XLEN-1:0]        entry;
  logic                    fetch_req;
  logic [`XLEN-1:0]        fetch_addr;
  logic                    fetch_valid;
  logic [`INSTR_WIDTH-1:0] fetch_data;
  logic                    mem_req;
  logic                    mem_we;
  logic [`XLEN-1:0]        mem_addr;
  logic [`XLEN-1:0]        mem_wdata;
  logic                    mem_ack;
  logic [`XLEN-1:0]        mem_rdata;
  core_pkg::wb_t           wb;

  logic [`REG_ADDR_WIDTH-1:0] exp_rd [$];
  logic [`XLEN-1:0]           exp_val [$];
  logic [`XLEN-1:0]           st_addr [$];
  logic [`XLEN-1:0]           st_val [$];
  int   p_count;
  int   e_idx;
  int   s_idx;
  int   retire_errs;
  int   store_errs;
  int   other_errs;
  logic loaded;
  logic fetched;     // First instruction word has arrived

  core_top u_core_top (
    .clk(clk), .reset(reset), .entry(entry),
    .fetch_req(fetch_req), .fetch_addr(fetch_addr),
    .fetch_valid(fetch_valid), .fetch_data(fetch_data),
    .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .mem_ack(mem_ack), .mem_rdata(mem_rdata), .wb(wb)
  );

  tb_memory u_tb_memory (
    .clk(clk), .fetch_req(fetch_req), .fetch_addr(fetch_addr),
    .fetch_valid(fetch_valid), .fetch_data(fetch_data),
    .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .mem_ack(mem_ack), .mem_rdata(mem_rdata)
  );

  always #5 clk = ~clk;

  task automatic load_expected();
    int               fd;
    int               n;
    string            line;
    string            tag;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] v;
    fd = $fopen("dv/core_golden.txt", "r");
    if (fd == 0) begin
      $display("Could not open dv/core_golden.txt");
      other_errs++;
      return;
    end
    while ($fgets(line, fd) > 0) begin
      n = $sscanf(line, "%s %h %h", tag, a, v);
      if (n != 3) continue;
      if (tag == "P") p_count++;
      else if (tag == "E") begin
        exp_rd.push_back(a[`REG_ADDR_WIDTH-1:0]);
        exp_val.push_back(v);
      end else if (tag == "S") begin
        st_addr.push_back(a);
        st_val.push_back(v);
      end
    end
    $fclose(fd);
  endtask

  // Pre-edge values of DUT outputs, all from flops or stable levels
  always @(posedge clk) begin
    if (!reset) begin
      if (fetch_valid) fetched <= 1'b1;
      assert (fetched || (!wb.valid && !mem_req)) else begin
        other_errs++;
        $display("ERR %0t: retire or data request before first fetch", $time);
      end
      if (wb.valid && e_idx < exp_rd.size()) begin
        assert (wb.rd == exp_rd[e_idx]) else begin
          retire_errs++;
          $display("ERR %0t: retire %0d rd x%0d, expected x%0d",
                   $time, e_idx, wb.rd, exp_rd[e_idx]);
        end
        // Value only matters for a register write
        if (exp_rd[e_idx] != '0) begin
          assert (wb.data == exp_val[e_idx]) else begin
            retire_errs++;
            $display("ERR %0t: retire %0d x%0d = %h, expected %h",
                     $time, e_idx, wb.rd, wb.data, exp_val[e_idx]);
          end
        end
        e_idx++;
      end else if (wb.valid) begin
        assert (wb.rd == '0) else begin
          retire_errs++;
          $display("ERR %0t: extra retire writes x%0d", $time, wb.rd);
        end
      end
      if (mem_req && mem_ack && mem_we) begin
        assert (s_idx < st_addr.size()) else begin
          store_errs++;
          $display("ERR %0t: unexpected store %h to %h", $time, mem_wdata, mem_addr);
        end
        if (s_idx < st_addr.size()) begin
          assert (mem_addr == st_addr[s_idx] && mem_wdata == st_val[s_idx]) else begin
            store_errs++;
            $display("ERR %0t: store %h to %h, expected %h to %h", $time,
                     mem_wdata, mem_addr, st_val[s_idx], st_addr[s_idx]);
          end
          s_idx++;
        end
      end
    end
  end

  initial begin
    wait (loaded);
    repeat (200 * p_count) @(posedge clk);
    $display("Watchdog expired after %0d cycles, only %0d of %0d retires seen",
             200 * p_count, e_idx, exp_rd.size());
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    clk         = 1'b0;
    reset       = 1'b1;
    entry       = '0;
    loaded      = 1'b0;
    fetched     = 1'b0;
    p_count     = 0;
    e_idx       = 0;
    s_idx       = 0;
    retire_errs = 0;
    store_errs  = 0;
    other_errs  = 0;
    load_expected();
    loaded = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    wait (e_idx == exp_rd.size());
    repeat (20) @(posedge clk);  // Window for leftover stores or writes
    assert (s_idx == st_addr.size()) else begin
      other_errs++;
      $display("Missing stores: saw %0d of %0d", s_idx, st_addr.size());
    end
    $display("Errors: retire %0d, store %0d, other %0d", retire_errs, store_errs, other_errs);
    if (retire_errs + store_errs + other_errs == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== dv/tb_memory.sv ====
`include "core_settings.svh"

module tb_memory (
  input  logic                    clk,
  input  logic                    fetch_req,
  input  logic [`XLEN-1:0]        fetch_addr,
  output logic                    fetch_valid,
  output logic [`INSTR_WIDTH-1:0] fetch_data,
  input  logic                    mem_req,
  input  logic                    mem_we,
  input  logic [`XLEN-1:0]        mem_addr,
  input  logic [`XLEN-1:0]        mem_wdata,
  output logic                    mem_ack,
  output logic [`XLEN-1:0]        mem_rdata
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [`INSTR_WIDTH-1:0] imem [logic [`XLEN-1:0]];
  logic [`XLEN-1:0]        dmem [logic [`XLEN-1:0]];
  int                      seed;
  logic                    i_busy;      // Fetch waiting for its answer
  logic                    d_busy;      // Data access waiting
  logic                    ack_now;
  int                      i_wait;
  int                      d_wait;
  logic [`XLEN-1:0]        i_addr;

  // Folds every address bit into 12 bits
  function automatic logic [11:0] fold(input logic [`XLEN-1:0] a);
    return a[11:0] ^ a[23:12] ^ a[35:24] ^ a[47:36] ^ a[59:48] ^ {8'h0, a[63:60]};
  endfunction

  function automatic logic [`INSTR_WIDTH-1:0] read_instr(input logic [`XLEN-1:0] a);
    if (imem.exists(a)) return imem[a];
    return {fold(a), 20'h00013};       // addi x0 filler, harmless if fetched
  endfunction

  function automatic logic [`XLEN-1:0] read_data(input logic [`XLEN-1:0] a);
    if (dmem.exists(a)) return dmem[a];
    return a ^ 64'h5a5a_a5a5_0f0f_f0f0;
  endfunction

  task automatic load_image();
    int               fd;
    int               n;
    string            line;
    string            tag;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] v;
    fd = $fopen("dv/core_golden.txt", "r");
    if (fd == 0) begin
      $display("Memory model could not open dv/core_golden.txt");
      return;
    end
    while ($fgets(line, fd) > 0) begin
      n = $sscanf(line, "%s %h %h", tag, a, v);
      if (n == 3 && tag == "P") imem[a] = v[`INSTR_WIDTH-1:0];
      else if (n == 3 && tag == "D") dmem[a] = v;
    end
    $fclose(fd);
  endtask

  initial begin
    seed        = 32'h84f5_4a08;
    fetch_valid = 1'b0;
    fetch_data  = '0;
    mem_ack     = 1'b0;
    mem_rdata   = '0;
    i_busy      = 1'b0;
    d_busy      = 1'b0;
    load_image();
  end

  // Answers after 0 to 3 extra cycles, everything driven on the falling edge
  always @(negedge clk) begin
    fetch_valid <= 1'b0;
    mem_ack     <= 1'b0;
    ack_now = 1'b0;
    if (i_busy) begin
      if (i_wait == 0) begin
        fetch_valid <= 1'b1;
        fetch_data  <= read_instr(i_addr);
        i_busy = 1'b0;
      end else i_wait--;
    end
    if (d_busy) begin
      if (d_wait == 0) begin
        mem_ack <= 1'b1;
        ack_now = 1'b1;
        if (mem_we) dmem[mem_addr] = mem_wdata;
        else mem_rdata <= read_data(mem_addr);
        d_busy = 1'b0;
      end else d_wait--;
    end
    if (fetch_req && !i_busy) begin
      i_busy = 1'b1;
      i_addr = fetch_addr;
      i_wait = $unsigned($random(seed)) % 4;
    end
    // Request still high during its ack cycle is not a new access
    if (mem_req && !d_busy && !ack_now && !mem_ack) begin
      d_busy = 1'b1;
      d_wait = $unsigned($random(seed)) % 4;
    end
  end

endmodule

// ==== flist.f ====
+incdir+include
verilog/core_pkg.sv
verilog/fetch_stage.sv
verilog/register_file.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/core_top.sv
dv/tb_memory.sv
dv/core_tb.sv

// ==== include/core_settings.svh ====
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Datapath widths
`define XLEN           64
`define INSTR_WIDTH    32
`define REG_ADDR_WIDTH 5
`define NUM_REGS       32
`define OPC_WIDTH      7
`define PC_STEP        4           // Fixed 32-bit encodings only

// Major opcode field, instr[6:0]
`define OPC_OP         7'b0110011  // ADD SUB AND OR XOR
`define OPC_OP_IMM     7'b0010011  // ADDI
`define OPC_LOAD       7'b0000011  // LD
`define OPC_STORE      7'b0100011  // SD
`define OPC_BRANCH     7'b1100011  // BEQ
`define OPC_JAL        7'b1101111

`endif

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module core_tb -f flist.f -o core_sim

./obj_dir/core_sim > sim.log 2>&1
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
  exit 1
fi
if ! grep -q "Simulation PASSED" sim.log; then
  echo "No pass line found in sim.log"
  exit 1
fi

// ==== verilog/core_pkg.sv ====
`include "core_settings.svh"

package core_pkg;

  // Supported major opcodes, anything else decodes as illegal
  typedef enum logic [`OPC_WIDTH-1:0] {
    OPC_ILLEGAL = `OPC_WIDTH'(0),
    OPC_OP      = `OPC_OP,
    OPC_OP_IMM  = `OPC_OP_IMM,
    OPC_LOAD    = `OPC_LOAD,
    OPC_STORE   = `OPC_STORE,
    OPC_BRANCH  = `OPC_BRANCH,
    OPC_JAL     = `OPC_JAL
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR
  } alu_op_e;

  // Decoded control, travels with the instruction down to memory
  typedef struct packed {
    opcode_e                    opcode;
    alu_op_e                    alu_op;
    logic [`XLEN-1:0]           imm;       // Sign extended, format per opcode
    logic                       use_imm;   // ALU operand b from imm
    logic                       mem_read;
    logic                       mem_write;
    logic                       is_branch; // BEQ
    logic                       is_jump;   // JAL
    logic                       reg_write;
    logic [`REG_ADDR_WIDTH-1:0] rd;
  } ctrl_t;

  typedef struct packed {
    logic                    valid;
    logic [`XLEN-1:0]        pc;
    logic [`INSTR_WIDTH-1:0] instr;
  } if_id_t;

  typedef struct packed {
    logic             valid;
    logic [`XLEN-1:0] pc;
    ctrl_t            ctrl;
    logic [`XLEN-1:0] rs1_val;
    logic [`XLEN-1:0] rs2_val;
  } id_ex_t;

  typedef struct packed {
    logic             valid;
    ctrl_t            ctrl;
    logic [`XLEN-1:0] result;     // ALU value, link or memory address
    logic [`XLEN-1:0] store_data;
  } ex_mem_t;

  // Retire record, rd is zero when nothing is written
  typedef struct packed {
    logic                       valid;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    logic [`XLEN-1:0]           data;
  } wb_t;

endpackage

// ==== verilog/core_top.sv ====
`include "core_settings.svh"

module core_top (
  input  logic                    clk,
  input  logic                    reset,
  input  logic [`XLEN-1:0]        entry,
  output logic                    fetch_req,
  output logic [`XLEN-1:0]        fetch_addr,
  input  logic                    fetch_valid,
  input  logic [`INSTR_WIDTH-1:0] fetch_data,
  output logic                    mem_req,
  output logic                    mem_we,
  output logic [`XLEN-1:0]        mem_addr,
  output logic [`XLEN-1:0]        mem_wdata,
  input  logic                    mem_ack,
  input  logic [`XLEN-1:0]        mem_rdata,
  output core_pkg::wb_t           wb
);

  core_pkg::if_id_t           if_id;
  core_pkg::id_ex_t           id_ex;
  core_pkg::ex_mem_t          ex_mem;
  logic                       redirect;
  logic [`XLEN-1:0]           redirect_pc;
  logic                       id_hold;   // Hold levels run back toward fetch
  logic                       ex_hold;
  logic                       mem_busy;
  logic [`REG_ADDR_WIDTH-1:0] rs1_addr;
  logic [`REG_ADDR_WIDTH-1:0] rs2_addr;
  logic [`XLEN-1:0]           rs1_data;
  logic [`XLEN-1:0]           rs2_data;

  fetch_stage u_fetch_stage (
    .clk         (clk),
    .reset       (reset),
    .entry       (entry),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .id_hold     (id_hold),
    .fetch_req   (fetch_req),
    .fetch_addr  (fetch_addr),
    .fetch_valid (fetch_valid),
    .fetch_data  (fetch_data),
    .if_id       (if_id)
  );

  register_file u_register_file (
    .clk      (clk),
    .reset    (reset),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb       (wb)
  );

  decode_stage u_decode_stage (
    .clk            (clk),
    .reset          (reset),
    .if_id          (if_id),
    .ex_hold        (ex_hold),
    .redirect       (redirect),
    .ex_rd_busy     (ex_mem),
    .mem_wb_pending (wb),
    .rs1_addr       (rs1_addr),
    .rs2_addr       (rs2_addr),
    .rs1_data       (rs1_data),
    .rs2_data       (rs2_data),
    .id_hold        (id_hold),
    .id_ex          (id_ex)
  );

  execute_stage u_execute_stage (
    .clk         (clk),
    .reset       (reset),
    .id_ex       (id_ex),
    .mem_busy    (mem_busy),
    .ex_hold     (ex_hold),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .ex_mem      (ex_mem)
  );

  memory_stage u_memory_stage (
    .clk       (clk),
    .reset     (reset),
    .ex_mem    (ex_mem),
    .mem_busy  (mem_busy),
    .mem_req   (mem_req),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata),
    .wb        (wb)
  );

endmodule

// ==== verilog/decode_stage.sv ====
`include "core_settings.svh"

module decode_stage (
  input  logic                       clk,
  input  logic                       reset,
  input  core_pkg::if_id_t           if_id,
  input  logic                       ex_hold,
  input  logic                       redirect,
  input  core_pkg::ex_mem_t          ex_rd_busy,     // Instruction in the memory stage
  input  core_pkg::wb_t              mem_wb_pending, // Record retiring this cycle
  output logic [`REG_ADDR_WIDTH-1:0] rs1_addr,
  output logic [`REG_ADDR_WIDTH-1:0] rs2_addr,
  input  logic [`XLEN-1:0]           rs1_data,
  input  logic [`XLEN-1:0]           rs2_data,
  output logic                       id_hold,
  output core_pkg::id_ex_t           id_ex
);

  logic [`INSTR_WIDTH-1:0] instr;
  logic [`XLEN-1:0]        imm_i;
  logic [`XLEN-1:0]        imm_s;
  logic [`XLEN-1:0]        imm_b;
  logic [`XLEN-1:0]        imm_j;
  core_pkg::ctrl_t         ctrl;
  logic                    need_rs1;
  logic                    need_rs2;
  logic                    rs1_busy;
  logic                    rs2_busy;
  logic                    raw;         // Source still owed by an older writer
  logic                    id_ex_stuck; // Execute not taking id_ex

  // funct3 to ALU op, sub from funct7[5] on register ops
  function automatic core_pkg::alu_op_e alu_sel(input logic [2:0] funct3, input logic sub);
    case (funct3)
      3'b000:  return sub ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
      3'b100:  return core_pkg::ALU_XOR;
      3'b110:  return core_pkg::ALU_OR;
      3'b111:  return core_pkg::ALU_AND;
      default: return core_pkg::ALU_ADD;
    endcase
  endfunction

  function automatic logic writes(input logic valid, input logic we,
                                  input logic [`REG_ADDR_WIDTH-1:0] rd,
                                  input logic [`REG_ADDR_WIDTH-1:0] src);
    return valid && we && (rd != '0) && (rd == src);
  endfunction

  assign instr    = if_id.instr;
  assign rs1_addr = instr[19:15];
  assign rs2_addr = instr[24:20];

  // I, S, B and J immediates, sign from bit 31
  assign imm_i = {{(`XLEN-12){instr[31]}}, instr[31:20]};
  assign imm_s = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{(`XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25],
                  instr[11:8], 1'b0};
  assign imm_j = {{(`XLEN-21){instr[31]}}, instr[31], instr[19:12], instr[20],
                  instr[30:21], 1'b0};

  always_comb begin
    ctrl        = '0;
    ctrl.opcode = core_pkg::OPC_ILLEGAL;   // Retires as a no-op
    ctrl.alu_op = core_pkg::ALU_ADD;
    ctrl.rd     = instr[11:7];
    case (instr[6:0])
      `OPC_OP: begin
        ctrl.opcode    = core_pkg::OPC_OP;
        ctrl.alu_op    = alu_sel(instr[14:12], instr[30]);
        ctrl.reg_write = 1'b1;
      end
      `OPC_OP_IMM: begin
        ctrl.opcode    = core_pkg::OPC_OP_IMM;
        ctrl.alu_op    = alu_sel(instr[14:12], 1'b0);
        ctrl.imm       = imm_i;
        ctrl.use_imm   = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      `OPC_LOAD: begin
        ctrl.opcode    = core_pkg::OPC_LOAD;  // Doubleword only
        ctrl.imm       = imm_i;
        ctrl.use_imm   = 1'b1;
        ctrl.mem_read  = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      `OPC_STORE: begin
        ctrl.opcode    = core_pkg::OPC_STORE;
        ctrl.imm       = imm_s;
        ctrl.use_imm   = 1'b1;
        ctrl.mem_write = 1'b1;
      end
      `OPC_BRANCH: begin
        ctrl.opcode    = core_pkg::OPC_BRANCH;  // Compare done in execute
        ctrl.imm       = imm_b;
        ctrl.is_branch = 1'b1;
      end
      `OPC_JAL: begin
        ctrl.opcode    = core_pkg::OPC_JAL;
        ctrl.imm       = imm_j;
        ctrl.is_jump   = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      default: ;
    endcase
  end

  // Only real source fields take part in the interlock
  assign need_rs1 = (ctrl.opcode != core_pkg::OPC_JAL) && (ctrl.opcode != core_pkg::OPC_ILLEGAL);
  assign need_rs2 = (ctrl.opcode == core_pkg::OPC_OP) || (ctrl.opcode == core_pkg::OPC_STORE)
                 || (ctrl.opcode == core_pkg::OPC_BRANCH);

  assign rs1_busy = writes(id_ex.valid, id_ex.ctrl.reg_write, id_ex.ctrl.rd, rs1_addr)
                 || writes(ex_rd_busy.valid, ex_rd_busy.ctrl.reg_write, ex_rd_busy.ctrl.rd, rs1_addr)
                 || writes(mem_wb_pending.valid, 1'b1, mem_wb_pending.rd, rs1_addr);
  assign rs2_busy = writes(id_ex.valid, id_ex.ctrl.reg_write, id_ex.ctrl.rd, rs2_addr)
                 || writes(ex_rd_busy.valid, ex_rd_busy.ctrl.reg_write, ex_rd_busy.ctrl.rd, rs2_addr)
                 || writes(mem_wb_pending.valid, 1'b1, mem_wb_pending.rd, rs2_addr);

  assign raw         = if_id.valid && ((need_rs1 && rs1_busy) || (need_rs2 && rs2_busy));
  assign id_ex_stuck = id_ex.valid && ex_hold;
  assign id_hold     = raw || id_ex_stuck;

  always_ff @(posedge clk) begin
    if (reset) begin
      id_ex.valid <= 1'b0;
    end else if (redirect) begin
      id_ex.valid <= 1'b0;                  // Younger than the taken branch
    end else if (!id_ex_stuck) begin
      id_ex.valid   <= if_id.valid && !raw; // Bubble while interlocked
      id_ex.pc      <= if_id.pc;
      id_ex.ctrl    <= ctrl;
      id_ex.rs1_val <= rs1_data;
      id_ex.rs2_val <= rs2_data;
    end
  end

endmodule

// ==== verilog/execute_stage.sv ====
`include "core_settings.svh"

module execute_stage (
  input  logic              clk,
  input  logic              reset,
  input  core_pkg::id_ex_t  id_ex,
  input  logic              mem_busy,
  output logic              ex_hold,
  output logic              redirect,
  output logic [`XLEN-1:0]  redirect_pc,
  output core_pkg::ex_mem_t ex_mem
);

  logic [`XLEN-1:0] op_b;
  logic [`XLEN-1:0] alu_out;
  logic [`XLEN-1:0] link;   // Return address for JAL
  logic             taken;

  assign op_b = id_ex.ctrl.use_imm ? id_ex.ctrl.imm : id_ex.rs2_val;

  // Also forms load and store addresses as rs1 plus imm
  always_comb begin
    case (id_ex.ctrl.alu_op)
      core_pkg::ALU_SUB: alu_out = id_ex.rs1_val - op_b;
      core_pkg::ALU_AND: alu_out = id_ex.rs1_val & op_b;
      core_pkg::ALU_OR:  alu_out = id_ex.rs1_val | op_b;
      core_pkg::ALU_XOR: alu_out = id_ex.rs1_val ^ op_b;
      default:           alu_out = id_ex.rs1_val + op_b;
    endcase
  end

  assign link  = id_ex.pc + `XLEN'(`PC_STEP);
  assign taken = id_ex.ctrl.is_jump
              || (id_ex.ctrl.is_branch && (id_ex.rs1_val == id_ex.rs2_val));  // BEQ

  assign ex_hold = ex_mem.valid && mem_busy;
  // Raised only in the cycle the branch moves into ex_mem
  assign redirect    = id_ex.valid && taken && !ex_hold;
  assign redirect_pc = id_ex.pc + id_ex.ctrl.imm;

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_mem.valid <= 1'b0;
    end else if (!ex_hold) begin
      ex_mem.valid      <= id_ex.valid;
      ex_mem.ctrl       <= id_ex.ctrl;
      ex_mem.result     <= id_ex.ctrl.is_jump ? link : alu_out;
      ex_mem.store_data <= id_ex.rs2_val;
    end
  end

  // Decode must have flushed its younger instruction a cycle later
  a_redirect_flush: assert property (@(posedge clk) disable iff (reset)
    redirect |-> id_ex.valid ##1 !id_ex.valid);

endmodule

// ==== verilog/fetch_stage.sv ====
`include "core_settings.svh"

module fetch_stage (
  input  logic                    clk,
  input  logic                    reset,
  input  logic [`XLEN-1:0]        entry,
  input  logic                    redirect,
  input  logic [`XLEN-1:0]        redirect_pc,
  input  logic                    id_hold,
  output logic                    fetch_req,
  output logic [`XLEN-1:0]        fetch_addr,
  input  logic                    fetch_valid,
  input  logic [`INSTR_WIDTH-1:0] fetch_data,
  output core_pkg::if_id_t        if_id
);

  logic [`XLEN-1:0] pc;      // Address of the next or outstanding fetch
  logic             started; // First cycle out of reset seen
  logic             req_due; // A request may go out
  logic             waiting; // Request issued, response outstanding
  logic             stale;   // Outstanding response belongs to a flushed path
  logic             resp_ok;

  assign fetch_addr = pc;
  // Hold off while decode keeps the current instruction
  assign fetch_req  = req_due && !(id_hold && if_id.valid) && !redirect;
  assign resp_ok    = fetch_valid && !stale && !redirect;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc          <= entry;
      started     <= 1'b0;
      req_due     <= 1'b0;
      waiting     <= 1'b0;
      stale       <= 1'b0;
      if_id.valid <= 1'b0;
    end else begin
      started <= 1'b1;
      if (redirect) begin
        pc <= redirect_pc;
      end else if (resp_ok) begin
        pc <= pc + `XLEN'(`PC_STEP);
      end

      if (fetch_req) begin
        waiting <= 1'b1;
      end else if (fetch_valid) begin
        waiting <= 1'b0;
      end

      // Response still in flight when the path changes
      if (redirect && waiting && !fetch_valid) begin
        stale <= 1'b1;
      end else if (fetch_valid) begin
        stale <= 1'b0;                     // Stale word dropped here
      end

      if (!started || fetch_valid) begin
        req_due <= 1'b1;                   // Next fetch at pc, new or redirected
      end else if (fetch_req) begin
        req_due <= 1'b0;
      end

      if (redirect) begin
        if_id.valid <= 1'b0;               // Flush younger instruction
      end else if (resp_ok) begin
        if_id.valid <= 1'b1;
        if_id.pc    <= pc;
        if_id.instr <= fetch_data;
      end else if (!id_hold) begin
        if_id.valid <= 1'b0;               // Taken by decode
      end
    end
  end

  // One outstanding fetch at a time
  a_single_outstanding: assert property (@(posedge clk) disable iff (reset)
    fetch_req |-> !waiting);

endmodule

// ==== verilog/memory_stage.sv ====
`include "core_settings.svh"

module memory_stage (
  input  logic              clk,
  input  logic              reset,
  input  core_pkg::ex_mem_t ex_mem,
  output logic              mem_busy,
  output logic              mem_req,
  output logic              mem_we,
  output logic [`XLEN-1:0]  mem_addr,
  output logic [`XLEN-1:0]  mem_wdata,
  input  logic              mem_ack,
  input  logic [`XLEN-1:0]  mem_rdata,
  output core_pkg::wb_t     wb
);

  logic access;   // Load or store sitting in ex_mem

  assign access   = ex_mem.valid && (ex_mem.ctrl.mem_read || ex_mem.ctrl.mem_write);
  assign mem_busy = access && !(mem_req && mem_ack);

  // Port fields come straight from ex_mem, held stable by mem_busy
  assign mem_we    = ex_mem.ctrl.mem_write;
  assign mem_addr  = ex_mem.result;
  assign mem_wdata = ex_mem.store_data;

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_req  <= 1'b0;
      wb.valid <= 1'b0;
    end else begin
      if (mem_req && mem_ack) begin
        mem_req <= 1'b0;                  // Access done, ex_mem moves on
      end else if (access) begin
        mem_req <= 1'b1;
      end

      wb.valid <= ex_mem.valid && !mem_busy;
      // Stores, branches and illegal ops retire with rd zero
      wb.rd    <= ex_mem.ctrl.reg_write ? ex_mem.ctrl.rd : '0;
      wb.data  <= ex_mem.ctrl.mem_read ? mem_rdata : ex_mem.result;
    end
  end

  // Request level and its payload stay put until acknowledged
  a_req_stable: assert property (@(posedge clk) disable iff (reset)
    mem_req && !mem_ack |=> mem_req && $stable(mem_addr) && $stable(mem_wdata));

endmodule

// ==== verilog/register_file.sv ====
`include "core_settings.svh"

module register_file (
  input  logic                       clk,
  input  logic                       reset,
  input  logic [`REG_ADDR_WIDTH-1:0] rs1_addr,
  input  logic [`REG_ADDR_WIDTH-1:0] rs2_addr,
  output logic [`XLEN-1:0]           rs1_data,
  output logic [`XLEN-1:0]           rs2_data,
  input  core_pkg::wb_t              wb
);

  logic [`XLEN-1:0] regs [`NUM_REGS];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.valid && wb.rd != '0) begin
      regs[wb.rd] <= wb.data;            // x0 never written, reads as zero
    end
  end

  // Same-cycle write shows through to the reader
  assign rs1_data = (wb.valid && wb.rd == rs1_addr && rs1_addr != '0) ? wb.data
                                                                       : regs[rs1_addr];
  assign rs2_data = (wb.valid && wb.rd == rs2_addr && rs2_addr != '0) ? wb.data
                                                                       : regs[rs2_addr];

endmodule
